/* hw/knights_tour_core.sv */
`timescale 1ns/1ps

module knights_tour_core (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [1:0]  adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack
);

  import kt_pkg::*;

  // Solver control
  logic              go;
  logic [2:0]        x_start;
  logic [2:0]        y_start;
  logic              busy;
  logic              done;
  logic [4:0]        host_indx;
  logic [move_w-1:0] host_move;

  // Replay side
  logic [4:0]        rep_indx;
  logic [move_w-1:0] rep_move;
  logic              replay_start;
  logic              cmd_pop;
  logic              cmd_valid;
  logic [1:0]        cmd_hdg;
  logic [1:0]        cmd_sq;
  logic [4:0]        cmd_indx;
  logic              replay_busy;
  logic [2:0]        pos_x;
  logic [2:0]        pos_y;

  //////////////////////////////////////////////////
  // Host registers
  //////////////////////////////////////////////////
  kt_wb_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .dat_r        (dat_r),
    .ack          (ack),
    .go           (go),
    .x_start      (x_start),
    .y_start      (y_start),
    .busy         (busy),
    .done         (done),
    .host_indx    (host_indx),
    .host_move    (host_move),
    .replay_start (replay_start),
    .cmd_pop      (cmd_pop),
    .cmd_valid    (cmd_valid),
    .cmd_hdg      (cmd_hdg),
    .cmd_sq       (cmd_sq),
    .cmd_indx     (cmd_indx),
    .replay_busy  (replay_busy),
    .pos_x        (pos_x),
    .pos_y        (pos_y)
  );

  // Backtracking search
  tour_logic u_tour (
    .clk       (clk),
    .rst_n     (rst_n),
    .go        (go),
    .x_start   (x_start),
    .y_start   (y_start),
    .host_indx (host_indx),
    .rep_indx  (rep_indx),
    .busy      (busy),
    .done      (done),
    .host_move (host_move),
    .rep_move  (rep_move)
  );

  // Leg command generator, shares the start square latched at go
  tour_replay u_replay (
    .clk          (clk),
    .rst_n        (rst_n),
    .replay_start (replay_start),
    .x_start      (x_start),
    .y_start      (y_start),
    .cmd_pop      (cmd_pop),
    .rep_indx     (rep_indx),
    .rep_move     (rep_move),
    .cmd_valid    (cmd_valid),
    .cmd_hdg      (cmd_hdg),
    .cmd_sq       (cmd_sq),
    .cmd_indx     (cmd_indx),
    .replay_busy  (replay_busy),
    .pos_x        (pos_x),
    .pos_y        (pos_y)
  );

endmodule

/* hw/kt_pkg.sv */
package kt_pkg;

  //////////////////////////////////////////////////
  // Board and tour sizes
  //////////////////////////////////////////////////
  localparam int board_dim = 5;   // Board is board_dim squares on a side
  localparam int tour_len  = 24;  // Moves in an open tour of the 5x5 board
  localparam int move_w    = 8;   // One bit per knight move direction

  localparam logic [move_w-1:0] move_first = 8'h01;  // First trial of every square
  localparam logic [move_w-1:0] move_last  = 8'h80;  // Last trial before backing up

  // Offsets of bit 0 to bit 7 of a one-hot move, in trial order
  localparam logic signed [2:0] move_x_off [move_w] =
    '{3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2, 3'sd2};
  localparam logic signed [2:0] move_y_off [move_w] =
    '{3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1};

  // Compass headings of a leg command, north is +y and east is +x
  localparam logic [1:0] hdg_n = 2'd0;
  localparam logic [1:0] hdg_e = 2'd1;
  localparam logic [1:0] hdg_s = 2'd2;
  localparam logic [1:0] hdg_w = 2'd3;

  // Word addresses of the host registers
  localparam logic [1:0] reg_ctrl = 2'd0;
  localparam logic [1:0] reg_cmd  = 2'd1;
  localparam logic [1:0] reg_move = 2'd2;
  localparam logic [1:0] reg_pos  = 2'd3;

  //////////////////////////////////////////////////
  // Move decode helpers
  //////////////////////////////////////////////////
  function automatic logic signed [2:0] move_dx(input logic [move_w-1:0] mv);
    logic signed [2:0] d;
    d = '0;                              // No bit set gives no offset
    for (int i = 0; i < move_w; i++) begin
      if (mv[i]) d = move_x_off[i];
    end
    return d;
  endfunction

  function automatic logic signed [2:0] move_dy(input logic [move_w-1:0] mv);
    logic signed [2:0] d;
    d = '0;
    for (int i = 0; i < move_w; i++) begin
      if (mv[i]) d = move_y_off[i];
    end
    return d;
  endfunction

  // Moves that land on the board when taken from square (x, y)
  function automatic logic [move_w-1:0] legal_mask(input logic [2:0] x, input logic [2:0] y);
    logic signed [4:0] nx;
    logic signed [4:0] ny;
    logic [move_w-1:0] m;
    m = '0;
    for (int i = 0; i < move_w; i++) begin
      nx   = $signed({2'b00, x}) + move_x_off[i];  // Widened so a step off the edge goes negative
      ny   = $signed({2'b00, y}) + move_y_off[i];
      m[i] = (nx >= 0) && (nx < board_dim) && (ny >= 0) && (ny < board_dim);
    end
    return m;
  endfunction

  // Heading of the two-square leg, taken along the axis that moves by two
  function automatic logic [1:0] leg_long_hdg(input logic [move_w-1:0] mv);
    logic signed [2:0] dx;
    logic signed [2:0] dy;
    logic              x_long;
    dx     = move_dx(mv);
    dy     = move_dy(mv);
    x_long = (dx == 3'sd2) || (dx == -3'sd2);
    if (x_long) return (dx > 3'sd0) ? hdg_e : hdg_w;
    return (dy > 3'sd0) ? hdg_n : hdg_s;
  endfunction

  // Heading of the one-square leg along the other axis
  function automatic logic [1:0] leg_short_hdg(input logic [move_w-1:0] mv);
    logic signed [2:0] dx;
    logic signed [2:0] dy;
    logic              x_long;
    dx     = move_dx(mv);
    dy     = move_dy(mv);
    x_long = (dx == 3'sd2) || (dx == -3'sd2);
    if (x_long) return (dy > 3'sd0) ? hdg_n : hdg_s;
    return (dx > 3'sd0) ? hdg_e : hdg_w;
  endfunction

endpackage

/* hw/kt_wb_regs.sv */
`timescale 1ns/1ps

module kt_wb_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [1:0]                adr,
  input  logic [31:0]               dat_w,
  output logic [31:0]               dat_r,
  output logic                      ack,
  output logic                      go,
  output logic [2:0]                x_start,
  output logic [2:0]                y_start,
  input  logic                      busy,
  input  logic                      done,
  output logic [4:0]                host_indx,
  input  logic [kt_pkg::move_w-1:0] host_move,
  output logic                      replay_start,
  output logic                      cmd_pop,
  input  logic                      cmd_valid,
  input  logic [1:0]                cmd_hdg,
  input  logic [1:0]                cmd_sq,
  input  logic [4:0]                cmd_indx,
  input  logic                      replay_busy,
  input  logic [2:0]                pos_x,
  input  logic [2:0]                pos_y
);

  import kt_pkg::*;

  logic access;   // Request cycle, ack follows at the next edge
  logic wr_ctrl;
  logic go_ok;
  logic rep_ok;
  logic solved;   // A complete tour is held in the solver

  assign access  = cyc && stb && !ack;
  assign wr_ctrl = access && we && (adr == reg_ctrl);

  // Bit 8 asks for a solve, bit 9 for a replay
  assign go_ok  = wr_ctrl && dat_w[8] && !busy;
  assign rep_ok = wr_ctrl && dat_w[9] && solved && !replay_busy && !replay_start && !go_ok;

  //////////////////////////////////////////////////
  // Handshake, pulses and control flags
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack          <= 1'b0;
      go           <= 1'b0;
      replay_start <= 1'b0;
      cmd_pop      <= 1'b0;
      solved       <= 1'b0;
      x_start      <= '0;
      y_start      <= '0;
      host_indx    <= '0;
    end else begin
      ack          <= access;   // Exactly one cycle since access drops while ack is high
      go           <= go_ok;
      replay_start <= rep_ok;
      cmd_pop      <= access && !we && (adr == reg_cmd) && cmd_valid;  // Pops with its ack
      if (go_ok) begin
        x_start <= dat_w[2:0];
        y_start <= dat_w[5:3];
        solved  <= 1'b0;
      end else if (done) begin
        solved <= 1'b1;
      end
      if (access && we && (adr == reg_move))
        host_indx <= dat_w[4:0];
    end
  end

  //////////////////////////////////////////////////
  // Read data, captured with the request
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (access && !we) begin
      case (adr)
        reg_ctrl: dat_r <= {28'd0, replay_busy, cmd_valid, solved, busy};
        reg_cmd: begin
          if (cmd_valid)
            dat_r <= {22'd0, 1'b1, cmd_indx, cmd_sq, cmd_hdg};
          else
            dat_r <= '0;   // Empty slot reads as all zero with valid low
        end
        reg_move: dat_r <= {24'd0, host_move};
        default:  dat_r <= {26'd0, pos_y, pos_x};   // reg_pos
      endcase
    end
  end

endmodule

/* hw/tour_logic.sv */
`timescale 1ns/1ps

module tour_logic (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      go,         // Start a new search from the given square
  input  logic [2:0]                x_start,
  input  logic [2:0]                y_start,
  input  logic [4:0]                host_indx,  // Move index read by the host registers
  input  logic [4:0]                rep_indx,   // Move index read by the replay unit
  output logic                      busy,
  output logic                      done,       // One cycle when the tour is complete
  output logic [kt_pkg::move_w-1:0] host_move,
  output logic [kt_pkg::move_w-1:0] rep_move
);

  import kt_pkg::*;

  typedef enum logic [2:0] {IDLE, INIT, POSSIBLE, MAKE_MOVE, BACKUP} state_t;

  //////////////////////////////////////////////////
  // Search state
  //////////////////////////////////////////////////
  logic [board_dim*board_dim-1:0] visited;        // One bit per square, set once the knight lands
  logic [move_w-1:0] last_move  [tour_len];       // Move taken from each index, the solution
  logic [move_w-1:0] poss_moves [tour_len];       // On-board moves from the square at each index
  logic [move_w-1:0] move_try;                    // One-hot move being tried now
  logic [4:0]        move_num;                    // Index of the move being searched
  logic [2:0]        xx;                          // Knight's current square
  logic [2:0]        yy;
  logic [2:0]        nxt_x;                       // Square reached by move_try
  logic [2:0]        nxt_y;
  logic [4:0]        cur_sq;
  logic [4:0]        nxt_sq;
  logic [move_w-1:0] prev_move;                   // Move that brought the knight here
  logic              move_ok;
  logic              last_step;

  state_t state;
  state_t state_nxt;

  // FSM strobes
  logic clr_board;   // Clear every square and load the start square
  logic init_pos;    // Mark the start square and restart the move count
  logic calc;        // Store the on-board moves of the current square
  logic advance;     // Record move_try and step onto its square
  logic next_try;    // Shift to the following trial move
  logic undo;        // Take back the last recorded move

  // Squares are numbered column by column with x selecting the column
  function automatic logic [4:0] sq_of(input logic [2:0] x, input logic [2:0] y);
    return ({2'b00, x} * 5'(board_dim)) + {2'b00, y};
  endfunction

  assign cur_sq    = sq_of(xx, yy);
  assign nxt_x     = xx + move_dx(move_try);          // Wraps off the board, masked below
  assign nxt_y     = yy + move_dy(move_try);
  assign nxt_sq    = sq_of(nxt_x, nxt_y);
  assign prev_move = last_move[move_num - 5'd1];
  assign last_step = (move_num == 5'(tour_len - 1));  // Recording this one finishes the tour

  // Mask first so an off-board square never looks at the visited bits
  assign move_ok = (|(poss_moves[move_num] & move_try)) && !visited[nxt_sq];

  assign busy      = (state != IDLE);
  assign host_move = last_move[host_indx];
  assign rep_move  = last_move[rep_indx];   // Plain combinational read for the replay

  //////////////////////////////////////////////////
  // Board and move stores
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (clr_board)
      visited <= '0;
    else if (init_pos)
      visited[cur_sq] <= 1'b1;   // Start square counts as visited
    else if (advance)
      visited[nxt_sq] <= 1'b1;
    else if (undo)
      visited[cur_sq] <= 1'b0;   // Leaving this square frees it again
  end

  always_ff @(posedge clk) begin
    if (calc)
      poss_moves[move_num] <= legal_mask(xx, yy);
  end

  always_ff @(posedge clk) begin
    if (advance)
      last_move[move_num] <= move_try;
  end

  // Position follows a recorded move forward or a taken-back move backward
  always_ff @(posedge clk) begin
    if (clr_board) begin
      xx <= x_start;
      yy <= y_start;
    end else if (advance) begin
      xx <= nxt_x;
      yy <= nxt_y;
    end else if (undo) begin
      xx <= xx - move_dx(prev_move);
      yy <= yy - move_dy(prev_move);
    end
  end

  always_ff @(posedge clk) begin
    if (init_pos)
      move_num <= '0;
    else if (advance && !last_step)
      move_num <= move_num + 5'd1;
    else if (undo)
      move_num <= move_num - 5'd1;
  end

  always_ff @(posedge clk) begin
    if (calc)
      move_try <= move_first;
    else if (next_try)
      move_try <= {move_try[move_w-2:0], 1'b0};
    else if (undo)
      move_try <= {prev_move[move_w-2:0], 1'b0};  // Resume after the move just taken back
  end

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= advance && last_step;  // Lines up with busy falling
    end
  end

  always_comb begin
    state_nxt = state;
    clr_board = 1'b0;
    init_pos  = 1'b0;
    calc      = 1'b0;
    advance   = 1'b0;
    next_try  = 1'b0;
    undo      = 1'b0;
    case (state)
      IDLE: begin
        if (go) begin
          clr_board = 1'b1;
          state_nxt = INIT;
        end
      end
      INIT: begin
        init_pos  = 1'b1;
        state_nxt = POSSIBLE;
      end
      POSSIBLE: begin
        calc      = 1'b1;   // Trial restarts at bit 0 on a fresh square
        state_nxt = MAKE_MOVE;
      end
      MAKE_MOVE: begin
        if (move_ok) begin
          advance   = 1'b1;
          state_nxt = last_step ? IDLE : POSSIBLE;
        end else if (move_try != move_last) begin
          next_try  = 1'b1;  // One cycle per rejected trial
        end else begin
          state_nxt = BACKUP;  // All eight used up here
        end
      end
      BACKUP: begin
        undo = 1'b1;
        // A previous move at the last trial has nothing left, keep unwinding
        if (prev_move != move_last)
          state_nxt = MAKE_MOVE;
      end
      default: state_nxt = IDLE;
    endcase
  end

endmodule

/* hw/tour_replay.sv */
`timescale 1ns/1ps

module tour_replay (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      replay_start,  // Pulse that starts a walk over the tour
  input  logic [2:0]                x_start,
  input  logic [2:0]                y_start,
  input  logic                      cmd_pop,       // Host has taken the held command
  output logic [4:0]                rep_indx,
  input  logic [kt_pkg::move_w-1:0] rep_move,
  output logic                      cmd_valid,
  output logic [1:0]                cmd_hdg,
  output logic [1:0]                cmd_sq,
  output logic [4:0]                cmd_indx,
  output logic                      replay_busy,
  output logic [2:0]                pos_x,
  output logic [2:0]                pos_y
);

  import kt_pkg::*;

  logic [4:0] idx;       // Stored move being split into legs
  logic       phase;     // Low for the long leg, high for the short leg
  logic       all_sent;  // Every move has been turned into legs
  logic       load;      // Move the next leg into the holding register

  assign rep_indx = idx;
  assign all_sent = (idx == 5'(tour_len));

  // A pop in the same cycle frees the slot for the next leg right away
  assign load = replay_busy && !all_sent && (!cmd_valid || cmd_pop);

  //////////////////////////////////////////////////
  // Walk counter and square tracking
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      replay_busy <= 1'b0;
      cmd_valid   <= 1'b0;
      idx         <= '0;
      phase       <= 1'b0;
      pos_x       <= '0;
      pos_y       <= '0;
    end else if (replay_start) begin
      replay_busy <= 1'b1;
      idx         <= '0;
      phase       <= 1'b0;
      pos_x       <= x_start;   // Walk begins on the square the solve started from
      pos_y       <= y_start;
    end else begin
      if (load) begin
        cmd_valid <= 1'b1;
        phase     <= !phase;
        if (phase) begin
          idx   <= idx + 5'd1;
          pos_x <= pos_x + move_dx(rep_move);  // Knight has reached the move's target
          pos_y <= pos_y + move_dy(rep_move);
        end
      end else if (cmd_pop) begin
        cmd_valid <= 1'b0;
        if (all_sent)
          replay_busy <= 1'b0;   // Final short leg was just taken
      end
    end
  end

  // Holding register for one leg command
  always_ff @(posedge clk) begin
    if (load) begin
      cmd_hdg  <= phase ? leg_short_hdg(rep_move) : leg_long_hdg(rep_move);
      cmd_sq   <= phase ? 2'd1 : 2'd2;
      cmd_indx <= idx;
    end
  end

endmodule

/* list.f */
hw/kt_pkg.sv
hw/tour_logic.sv
hw/tour_replay.sv
hw/kt_wb_regs.sv
hw/knights_tour_core.sv
test/kt_checker.sv
test/tb_knights_tour.sv

/* test/kt_checker.sv */
`timescale 1ns/1ps

module kt_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        cyc,
  input logic        stb,
  input logic        we,
  input logic [1:0]  adr,
  input logic [31:0] dat_w,
  input logic [31:0] dat_r,
  input logic        ack
);

  import kt_pkg::*;

  // Knight offsets of bit 0 to bit 7 of a move code, in trial order
  int dx_tab [8] = '{1, -1, -2, -2, -1, 1, 2, 2};
  int dy_tab [8] = '{2, 2, 1, -1, -2, -2, -1, 1};

  int    err_total    = 0;
  int    test_err     = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  string test_name;

  logic        req_seen;   // Request sampled at the previous edge
  logic        ack_last;
  logic [1:0]  req_adr;
  logic        req_we;
  logic [31:0] req_dat;

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////
  logic       solving;              // A go was accepted and solved not yet seen
  logic       solved;
  logic       rep_active;           // Replay running, commands still owed
  int         start_x;
  int         start_y;
  int         px;                   // Knight's square after the last popped short leg
  int         py;
  int         pops;
  int         move_idx;
  logic [7:0] tour [24];            // Moves read back through reg_move
  logic [7:0] ref_tour [25][24];    // First tour seen from each start square
  logic       has_ref [25];

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail at %0d ns: %s got %h expected %h", $time, sig, got, exp);
    err_total++;
    test_err++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    err_total++;
    test_err++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err  = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_err == 0) begin
      $display("Test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, test_err);
    end
  endtask

  task automatic report_counts();
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, err_total);
  endtask

  function automatic int bit_of(input logic [7:0] m);
    for (int i = 0; i < 8; i++) begin
      if (m[i]) return i;
    end
    return 0;
  endfunction

  // Long leg runs along the axis that moves by two, the short leg along the other
  function automatic logic [31:0] expected_cmd(input logic [7:0] m, input int leg,
                                               input int idx);
    int         dx;
    int         dy;
    logic       x_long;
    logic [1:0] hdg;
    dx     = dx_tab[bit_of(m)];
    dy     = dy_tab[bit_of(m)];
    x_long = (dx == 2) || (dx == -2);
    if (x_long == (leg == 0))
      hdg = (dx > 0) ? hdg_e : hdg_w;   // This leg steps along x
    else
      hdg = (dy > 0) ? hdg_n : hdg_s;
    return {22'd0, 1'b1, 5'(idx), (leg == 0) ? 2'd2 : 2'd1, hdg};
  endfunction

  // Walks the tour from the start square and compares it with an earlier solve
  task automatic check_tour();
    logic [24:0] seen;
    int          x;
    int          y;
    int          sq;
    logic        ok;
    x        = start_x;
    y        = start_y;
    seen     = '0;
    seen[x*5+y] = 1'b1;
    ok       = 1'b1;
    for (int i = 0; i < 24 && ok; i++) begin
      if ($countones(tour[i]) != 1) begin
        report_problem($sformatf("move %0d code %h is not one-hot", i, tour[i]));
        ok = 1'b0;
      end else begin
        x += dx_tab[bit_of(tour[i])];
        y += dy_tab[bit_of(tour[i])];
        if (x < 0 || x > 4 || y < 0 || y > 4) begin
          report_problem($sformatf("move %0d leaves the board", i));
          ok = 1'b0;
        end else if (seen[x*5+y]) begin
          report_problem($sformatf("move %0d lands on a visited square", i));
          ok = 1'b0;
        end else begin
          seen[x*5+y] = 1'b1;
        end
      end
    end
    if (ok && seen != '1) report_problem("tour does not cover all 25 squares");
    sq = start_x * 5 + start_y;
    if (has_ref[sq]) begin
      for (int i = 0; i < 24; i++) begin
        if (tour[i] !== ref_tour[sq][i])
          report_mismatch($sformatf("move[%0d]", i), tour[i], ref_tour[sq][i]);
      end
    end else begin
      for (int i = 0; i < 24; i++) ref_tour[sq][i] = tour[i];
      has_ref[sq] = 1'b1;
    end
  endtask

  // Applies one finished bus access to the model and checks its read data
  task automatic complete_access();
    logic [31:0] exp;
    logic        ra;
    ra = rep_active;
    if (req_we) begin
      if (req_adr == reg_ctrl && req_dat[8] && !solving) begin
        start_x = req_dat[2:0];
        start_y = req_dat[5:3];
        solving = 1'b1;
        solved  = 1'b0;
      end else if (req_adr == reg_ctrl && req_dat[9] && solved && !rep_active) begin
        rep_active = 1'b1;
        pops       = 0;
        px         = start_x;   // Replay walks from the solve's start square
        py         = start_y;
      end else if (req_adr == reg_move) begin
        move_idx = req_dat[4:0];
      end
    end else begin
      case (req_adr)
        reg_ctrl: begin
          exp = {28'd0, ra, ra, solved, 1'b0};
          if (solving) begin
            exp = {28'd0, ra, ra, 2'b01};   // Still searching
            if (dat_r === {28'd0, ra, ra, 2'b10}) begin
              solving = 1'b0;
              solved  = 1'b1;
              exp     = dat_r;
            end else if (dat_r === {28'd0, ra, ra, 2'b00}) begin
              exp = dat_r;   // Done cycle, busy has dropped and solved is set one edge later
            end
          end
          if (dat_r !== exp) report_mismatch("dat_r (reg_ctrl)", dat_r, exp);
        end
        reg_cmd: begin
          exp = '0;   // Empty slot reads as zero
          if (rep_active) exp = expected_cmd(tour[pops/2], pops % 2, pops / 2);
          if (dat_r !== exp) report_mismatch("dat_r (reg_cmd)", dat_r, exp);
          if (rep_active) begin
            pops++;
            if (pops % 2 == 0) begin
              px += dx_tab[bit_of(tour[pops/2-1])];   // Short leg finishes the move
              py += dy_tab[bit_of(tour[pops/2-1])];
            end
            if (pops == 48) rep_active = 1'b0;
          end
        end
        reg_move: begin
          if (dat_r[31:8] !== 24'd0)
            report_mismatch("dat_r (reg_move)", dat_r, {24'd0, dat_r[7:0]});
          if (move_idx < 24) tour[move_idx] = dat_r[7:0];
          if (move_idx == 23) check_tour();
        end
        default: begin
          exp = {26'd0, 3'(py), 3'(px)};
          if (pops % 2 == 0 && dat_r !== exp) report_mismatch("dat_r (reg_pos)", dat_r, exp);
        end
      endcase
    end
  endtask

  //////////////////////////////////////////////////
  // Bus monitor
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst_n) begin
      req_seen   = 1'b0;
      ack_last   = 1'b0;
      solving    = 1'b0;
      solved     = 1'b0;
      rep_active = 1'b0;
      pops       = 0;
      px         = 0;
      py         = 0;
      move_idx   = 0;
      for (int i = 0; i < 25; i++) has_ref[i] = 1'b0;
    end else begin
      if (ack && ack_last) report_problem("ack stayed high for more than one cycle");
      if (ack && !req_seen) report_problem("ack arrived without a request");
      if (req_seen && !ack) report_problem("no ack in the cycle after a request");
      if (ack && req_seen) complete_access();
      req_seen = cyc && stb && !ack;   // Ack is due at the next edge
      if (req_seen) begin
        req_adr = adr;
        req_we  = we;
        req_dat = dat_w;
      end
      ack_last = ack;
    end
  end

endmodule

/* test/tb_knights_tour.sv */
`timescale 1ns/1ps

module tb_knights_tour;

  import kt_pkg::*;

  localparam int solve_count = 6;                                // Four random, two repeated
  localparam int cycle_limit = solve_count * 2_000_000 + 20_000;

  logic        clk;
  logic        rst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [1:0]  adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;
  logic [31:0] rng;   // Xorshift state
  logic [31:0] rd;
  logic [2:0]  sx;
  logic [2:0]  sy;
  int          cycles;

  knights_tour_core u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  kt_checker u_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // Ends a run that never reaches its summary
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  //////////////////////////////////////////////////
  // Wishbone master, driven on the falling edge
  //////////////////////////////////////////////////
  task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = a;
    dat_w = d;
    @(negedge clk);
    while (!ack) @(negedge clk);
    cyc = 1'b0;   // Drop the strobe once the ack is seen
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] a, output logic [31:0] d);
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = a;
    @(negedge clk);
    while (!ack) @(negedge clk);
    d   = dat_r;   // Valid for the whole ack cycle
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Random square with x plus y even
  task automatic pick_start(output logic [2:0] x, output logic [2:0] y);
    rng = xorshift(rng);
    x   = 3'(rng[7:0] % 5);
    y   = 3'(rng[15:8] % 5);
    if (x[0] != y[0]) y = (y == 3'd4) ? 3'd3 : y + 3'd1;
  endtask

  task automatic start_solve(input logic [2:0] x, input logic [2:0] y);
    write_reg(reg_ctrl, {22'd0, 1'b0, 1'b1, 2'b00, y, x});   // Go in bit 8
  endtask

  task automatic wait_solved();
    logic [31:0] d;
    read_reg(reg_ctrl, d);
    while (!d[1]) read_reg(reg_ctrl, d);
  endtask

  task automatic read_tour();
    logic [31:0] d;
    for (int i = 0; i < tour_len; i++) begin
      write_reg(reg_move, 32'(i));
      read_reg(reg_move, d);
    end
  endtask

  // First command is due two cycles after the replay write, so every gap is at least two
  task automatic run_replay(input int max_gap, input logic check_pos);
    logic [31:0] d;
    write_reg(reg_ctrl, 32'h0000_0200);
    for (int i = 0; i < 2 * tour_len; i++) begin
      rng = xorshift(rng);
      idle_cycles(2 + int'(rng[7:0] % max_gap));
      read_reg(reg_cmd, d);
      if (check_pos && (i % 2 == 1)) read_reg(reg_pos, d);   // After each short leg
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    rng   = 32'ha3c5_e93b;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    u_chk.begin_test("reset_state");
    read_reg(reg_ctrl, rd);
    read_reg(reg_pos, rd);
    read_reg(reg_cmd, rd);
    u_chk.end_test();

    u_chk.begin_test("tour_legality");
    repeat (4) begin
      pick_start(sx, sy);
      start_solve(sx, sy);
      wait_solved();
      read_tour();
    end
    u_chk.end_test();

    u_chk.begin_test("determinism");
    pick_start(sx, sy);
    start_solve(sx, sy);
    // A different square that arrives while the solver is busy
    start_solve((sx == 3'd2) ? 3'd0 : 3'd4 - sx, 3'd4 - sy);
    wait_solved();
    read_tour();
    start_solve(sx, sy);
    wait_solved();
    read_tour();
    u_chk.end_test();

    u_chk.begin_test("replay_commands");
    run_replay(1, 1'b0);
    u_chk.end_test();

    u_chk.begin_test("position_backpressure");
    run_replay(8, 1'b1);
    idle_cycles(2);
    read_reg(reg_ctrl, rd);   // Replay busy and command valid both low now
    read_reg(reg_cmd, rd);
    u_chk.end_test();

    u_chk.report_counts();
    if (u_chk.err_total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
